// ==== router_arb_pkg.sv ====
// router arbitration package, shared port codes, vector types and candidate slot mapping
package router_arb_pkg;

        // router geometry
        localparam int NUM_PORTS = 5;
        localparam int NUM_CAND  = 4;

        // next-hop / output port code
        typedef enum logic [2:0] {
                PORT_N    = 3'd0,
                PORT_S    = 3'd1,
                PORT_W    = 3'd2,
                PORT_E    = 3'd3,
                PORT_L    = 3'd4,
                PORT_NONE = 3'd7
        } port_t;

        // one bit per router port, indexed by port code
        typedef logic [NUM_PORTS-1:0] port_vec_t;

        // one bit per candidate slot
        typedef logic [NUM_CAND-1:0] cand_vec_t;

        // candidate slot index
        typedef logic [1:0] slot_t;

        // slot to port code for a given output
        // the four other ports sit in ascending order, the output itself is skipped
        function automatic port_t cand_port(input port_t out_port, input slot_t slot);
                logic [2:0] code;
                code = {1'b0, slot};
                if (code >= out_port) begin
                        code = code + 3'd1;
                end
                return port_t'(code);
        endfunction

endpackage

// ==== nexthop_if.sv ====
// next-hop bundle, carries the routed port code of every input's head flit
`timescale 1ns/100ps

interface nexthop_if import router_arb_pkg::*; ();

        // one code per input port, PORT_NONE when that input is idle
        port_t n_hop;
        port_t s_hop;
        port_t w_hop;
        port_t e_hop;
        port_t l_hop;

        // driven by the router top from its input pins
        modport src (
                output n_hop,
                output s_hop,
                output w_hop,
                output e_hop,
                output l_hop
        );

        // read by every output port arbiter
        modport arb (
                input n_hop,
                input s_hop,
                input w_hop,
                input e_hop,
                input l_hop
        );

endinterface

// ==== rr_request_decoder.sv ====
// request decoder, marks the candidate inputs whose next hop is this output port
`timescale 1ns/100ps

module rr_request_decoder import router_arb_pkg::*; #(
        parameter port_t OUT_PORT = PORT_N
) (
        nexthop_if.arb  hops,
        output cand_vec_t req_o
);

        // codes gathered into an array indexed by input port
        port_t hop_of [NUM_PORTS];

        assign hop_of[PORT_N] = hops.n_hop;
        assign hop_of[PORT_S] = hops.s_hop;
        assign hop_of[PORT_W] = hops.w_hop;
        assign hop_of[PORT_E] = hops.e_hop;
        assign hop_of[PORT_L] = hops.l_hop;

        // one compare per slot
        // own input is never a slot, so a u-turn cannot raise a request
        always_comb begin
                req_o = '0;
                for (int s = 0; s < NUM_CAND; s++) begin
                        if (hop_of[cand_port(OUT_PORT, slot_t'(s))] == OUT_PORT) begin
                                req_o[s] = 1'b1;
                        end
                end
        end

endmodule

// ==== rr_order_register.sv ====
// round-robin order register, one-hot priority pointer rotated by the change-order strobe
`timescale 1ns/100ps

module rr_order_register import router_arb_pkg::*; (
        input  logic      clk,
        input  logic      arst_n_i,
        input  logic      change_order_i,
        output cand_vec_t order_o
);

        // strobe sampled on the edge, new pointer seen from the next cycle
        // rotate left, slot k hands over to slot k+1, top slot wraps to 0
        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        // pointer starts on slot 0
                        order_o <= cand_vec_t'(1);
                end else if (change_order_i) begin
                        order_o <= {order_o[NUM_CAND-2:0], order_o[NUM_CAND-1]};
                end
        end

endmodule

// ==== rr_priority_encoder.sv ====
// cyclic priority encoder, grants the first requesting slot at or after the pointer
`timescale 1ns/100ps

module rr_priority_encoder import router_arb_pkg::*; (
        input  cand_vec_t req_i,
        input  cand_vec_t order_i,
        output cand_vec_t gnt_o,
        output slot_t     win_o,
        output logic      any_o
);

        // pointer position as a slot index
        slot_t ptr_slot;

        // one-hot to index, pointer is always one-hot
        always_comb begin
                ptr_slot = '0;
                for (int s = 0; s < NUM_CAND; s++) begin
                        if (order_i[s]) begin
                                ptr_slot = slot_t'(s);
                        end
                end
        end

        // walk the slots starting at the pointer
        // 2-bit slot index wraps from slot 3 back to slot 0
        always_comb begin
                slot_t probe;
                logic  found;
                gnt_o = '0;
                win_o = '0;
                found = 1'b0;
                for (int k = 0; k < NUM_CAND; k++) begin
                        probe = ptr_slot + slot_t'(k);
                        if (!found && req_i[probe]) begin
                                found        = 1'b1;
                                win_o        = probe;
                                gnt_o[probe] = 1'b1;
                        end
                end
        end

        // any request at all means a grant goes out
        assign any_o = |req_i;

endmodule

// ==== rr_port_arbiter.sv ====
// output port arbiter, round-robin choice among the four other inputs for one output
`timescale 1ns/100ps

module rr_port_arbiter import router_arb_pkg::*; #(
        parameter port_t OUT_PORT = PORT_N
) (
        input  logic      clk,
        input  logic      arst_n_i,
        nexthop_if.arb    hops,
        input  logic      change_order_i,
        output port_vec_t grant_o,
        output port_t     sel_o,
        output logic      valid_o
);

        cand_vec_t slot_req;
        cand_vec_t slot_order;
        cand_vec_t slot_gnt;
        slot_t     slot_win;
        logic      any_req;

        // which of the other inputs want this output
        rr_request_decoder #(
                .OUT_PORT (OUT_PORT)
        ) i_rr_request_decoder (
                .hops  (hops),
                .req_o (slot_req)
        );

        // rotating priority pointer
        rr_order_register i_rr_order_register (
                .clk            (clk),
                .arst_n_i       (arst_n_i),
                .change_order_i (change_order_i),
                .order_o        (slot_order)
        );

        // first requester from the pointer on
        rr_priority_encoder i_rr_priority_encoder (
                .req_i   (slot_req),
                .order_i (slot_order),
                .gnt_o   (slot_gnt),
                .win_o   (slot_win),
                .any_o   (any_req)
        );

        // slot grant back onto port code positions
        always_comb begin
                grant_o = '0;
                for (int s = 0; s < NUM_CAND; s++) begin
                        if (slot_gnt[s]) begin
                                grant_o[cand_port(OUT_PORT, slot_t'(s))] = 1'b1;
                        end
                end
        end

        // crossbar select, PORT_NONE while nobody is granted
        assign sel_o   = any_req ? cand_port(OUT_PORT, slot_win) : PORT_NONE;
        assign valid_o = any_req;

endmodule

// ==== router_arbiter_top.sv ====
// router arbitration top, five round-robin output arbiters fed from the next-hop codes
`timescale 1ns/100ps

module router_arbiter_top import router_arb_pkg::*; (
        input  logic      clk,
        input  logic      arst_n_i,

        // next-hop code per input, PORT_NONE when idle
        input  port_t     n_hop_i,
        input  port_t     s_hop_i,
        input  port_t     w_hop_i,
        input  port_t     e_hop_i,
        input  port_t     l_hop_i,

        // one change-order strobe per output port
        input  port_vec_t change_order_i,

        // grant vector per output, indexed by input port code
        output port_vec_t n_grant_o,
        output port_vec_t s_grant_o,
        output port_vec_t w_grant_o,
        output port_vec_t e_grant_o,
        output port_vec_t l_grant_o,

        // crossbar select per output
        output port_t     n_sel_o,
        output port_t     s_sel_o,
        output port_t     w_sel_o,
        output port_t     e_sel_o,
        output port_t     l_sel_o,

        // grant valid, indexed by output port
        output port_vec_t valid_o
);

        // top acts as the source side of the bundle
        nexthop_if hop_bus ();

        assign hop_bus.n_hop = n_hop_i;
        assign hop_bus.s_hop = s_hop_i;
        assign hop_bus.w_hop = w_hop_i;
        assign hop_bus.e_hop = e_hop_i;
        assign hop_bus.l_hop = l_hop_i;

        // north output
        rr_port_arbiter #(.OUT_PORT(PORT_N)) i_rr_port_arbiter_n (
                .clk            (clk),
                .arst_n_i       (arst_n_i),
                .hops           (hop_bus.arb),
                .change_order_i (change_order_i[PORT_N]),
                .grant_o        (n_grant_o),
                .sel_o          (n_sel_o),
                .valid_o        (valid_o[PORT_N])
        );

        // south output
        rr_port_arbiter #(.OUT_PORT(PORT_S)) i_rr_port_arbiter_s (
                .clk            (clk),
                .arst_n_i       (arst_n_i),
                .hops           (hop_bus.arb),
                .change_order_i (change_order_i[PORT_S]),
                .grant_o        (s_grant_o),
                .sel_o          (s_sel_o),
                .valid_o        (valid_o[PORT_S])
        );

        // west output
        rr_port_arbiter #(.OUT_PORT(PORT_W)) i_rr_port_arbiter_w (
                .clk            (clk),
                .arst_n_i       (arst_n_i),
                .hops           (hop_bus.arb),
                .change_order_i (change_order_i[PORT_W]),
                .grant_o        (w_grant_o),
                .sel_o          (w_sel_o),
                .valid_o        (valid_o[PORT_W])
        );

        // east output
        rr_port_arbiter #(.OUT_PORT(PORT_E)) i_rr_port_arbiter_e (
                .clk            (clk),
                .arst_n_i       (arst_n_i),
                .hops           (hop_bus.arb),
                .change_order_i (change_order_i[PORT_E]),
                .grant_o        (e_grant_o),
                .sel_o          (e_sel_o),
                .valid_o        (valid_o[PORT_E])
        );

        // local output, toward the attached core
        rr_port_arbiter #(.OUT_PORT(PORT_L)) i_rr_port_arbiter_l (
                .clk            (clk),
                .arst_n_i       (arst_n_i),
                .hops           (hop_bus.arb),
                .change_order_i (change_order_i[PORT_L]),
                .grant_o        (l_grant_o),
                .sel_o          (l_sel_o),
                .valid_o        (valid_o[PORT_L])
        );

endmodule

// ==== tb_router_arbiter.sv ====
// router arbitration testbench, directed table then random cycles against a round-robin model
`timescale 1ns/100ps

module tb_router_arbiter import router_arb_pkg::*; ();

        localparam int    RST_CYCLES  = 2;
        localparam int    NUM_ROWS    = 17;
        localparam int    RAND_CYCLES = 300;
        localparam int    MAX_CYCLES  = 2 * (RST_CYCLES + NUM_ROWS + RAND_CYCLES);
        localparam port_t IDLE        = PORT_NONE;

        logic      clk;
        logic      arst_n_i;
        port_t     n_hop_i;
        port_t     s_hop_i;
        port_t     w_hop_i;
        port_t     e_hop_i;
        port_t     l_hop_i;
        port_vec_t change_order_i;
        port_vec_t n_grant_o;
        port_vec_t s_grant_o;
        port_vec_t w_grant_o;
        port_vec_t e_grant_o;
        port_vec_t l_grant_o;
        port_t     n_sel_o;
        port_t     s_sel_o;
        port_t     w_sel_o;
        port_t     e_sel_o;
        port_t     l_sel_o;
        port_vec_t valid_o;

        // outputs gathered by output port code
        port_t     act_sel   [NUM_PORTS];
        port_vec_t act_grant [NUM_PORTS];

        // directed table, five 3-bit codes packed with north in the top bits
        logic [14:0] tbl_hops   [NUM_ROWS];
        port_vec_t   tbl_strobe [NUM_ROWS];
        logic [14:0] tbl_sel    [NUM_ROWS];
        port_vec_t   tbl_valid  [NUM_ROWS];

        // stimulus and expectation of the current cycle
        port_t     cur_hop   [NUM_PORTS];
        port_vec_t cur_strobe;
        port_t     exp_sel   [NUM_PORTS];
        port_vec_t exp_valid;

        // model pointer per output, as a slot index
        int        model_ptr [NUM_PORTS];
        int        cycle_cnt = 0;
        integer    seed;
        string     port_name [NUM_PORTS] = '{"north", "south", "west", "east", "local"};

        router_arbiter_top i_router_arbiter_top (
                .clk            (clk),
                .arst_n_i       (arst_n_i),
                .n_hop_i        (n_hop_i),
                .s_hop_i        (s_hop_i),
                .w_hop_i        (w_hop_i),
                .e_hop_i        (e_hop_i),
                .l_hop_i        (l_hop_i),
                .change_order_i (change_order_i),
                .n_grant_o      (n_grant_o),
                .s_grant_o      (s_grant_o),
                .w_grant_o      (w_grant_o),
                .e_grant_o      (e_grant_o),
                .l_grant_o      (l_grant_o),
                .n_sel_o        (n_sel_o),
                .s_sel_o        (s_sel_o),
                .w_sel_o        (w_sel_o),
                .e_sel_o        (e_sel_o),
                .l_sel_o        (l_sel_o),
                .valid_o        (valid_o)
        );

        assign act_sel[PORT_N]   = n_sel_o;
        assign act_sel[PORT_S]   = s_sel_o;
        assign act_sel[PORT_W]   = w_sel_o;
        assign act_sel[PORT_E]   = e_sel_o;
        assign act_sel[PORT_L]   = l_sel_o;
        assign act_grant[PORT_N] = n_grant_o;
        assign act_grant[PORT_S] = s_grant_o;
        assign act_grant[PORT_W] = w_grant_o;
        assign act_grant[PORT_E] = e_grant_o;
        assign act_grant[PORT_L] = l_grant_o;

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        // run limit
        always @(posedge clk) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= MAX_CYCLES) begin
                        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
                        $display("CHECKS FAILED");
                        $fatal(1, "run stopped by the cycle limit");
                end
        end

        task automatic check_sel(input string what, input port_t exp, input port_t act);
                if (act !== exp) begin
                        $display("[ERROR] %0t ns: %s sel expected %0d got %0d",
                                 $time, what, exp, act);
                        $display("CHECKS FAILED");
                        $fatal(1, "sel mismatch");
                end
        endtask

        task automatic check_grant(input string what, input port_vec_t exp, input port_vec_t act);
                if (act !== exp) begin
                        $display("[ERROR] %0t ns: %s grant expected %b got %b",
                                 $time, what, exp, act);
                        $display("CHECKS FAILED");
                        $fatal(1, "grant mismatch");
                end
        endtask

        task automatic check_valid(input string what, input logic exp, input logic act);
                if (act !== exp) begin
                        $display("[ERROR] %0t ns: %s valid expected %b got %b",
                                 $time, what, exp, act);
                        $display("CHECKS FAILED");
                        $fatal(1, "valid mismatch");
                end
        endtask

        task automatic set_row(input int idx, input logic [14:0] hops, input port_vec_t strobe,
                               input logic [14:0] sels, input port_vec_t valid);
                tbl_hops[idx]   = hops;
                tbl_strobe[idx] = strobe;
                tbl_sel[idx]    = sels;
                tbl_valid[idx]  = valid;
        endtask

        function automatic port_t code_at(input logic [14:0] v, input int p);
                return port_t'(v[14-3*p -: 3]);
        endfunction

        // slot s of output p, the other ports in ascending order
        function automatic int other_port(input int out_p, input int slot);
                return (slot < out_p) ? slot : slot + 1;
        endfunction

        // first requesting slot from the model pointer on, 7 when nobody asks
        function automatic int model_winner(input int out_p);
                int slot;
                int src;
                for (int k = 0; k < NUM_CAND; k++) begin
                        slot = (model_ptr[out_p] + k) % NUM_CAND;
                        src  = other_port(out_p, slot);
                        if (cur_hop[src] == port_t'(out_p)) begin
                                return src;
                        end
                end
                return 7;
        endfunction

        task automatic drive_cycle();
                @(posedge clk);
                n_hop_i        <= cur_hop[PORT_N];
                s_hop_i        <= cur_hop[PORT_S];
                w_hop_i        <= cur_hop[PORT_W];
                e_hop_i        <= cur_hop[PORT_E];
                l_hop_i        <= cur_hop[PORT_L];
                change_order_i <= cur_strobe;
                @(negedge clk);
        endtask

        task automatic check_all();
                port_vec_t exp_grant;
                for (int p = 0; p < NUM_PORTS; p++) begin
                        exp_grant = exp_valid[p] ? port_vec_t'(1) << exp_sel[p] : '0;
                        check_sel(port_name[p], exp_sel[p], act_sel[p]);
                        check_grant(port_name[p], exp_grant, act_grant[p]);
                        check_valid(port_name[p], exp_valid[p], valid_o[p]);
                end
        endtask

        // strobe seen at the next edge moves the pointer for the cycle after
        task automatic advance_model();
                for (int p = 0; p < NUM_PORTS; p++) begin
                        if (cur_strobe[p]) begin
                                model_ptr[p] = (model_ptr[p] + 1) % NUM_CAND;
                        end
                end
        endtask

        task automatic load_table();
                set_row(0, {IDLE, IDLE, IDLE, IDLE, IDLE}, 5'b00000,
                        {IDLE, IDLE, IDLE, IDLE, IDLE}, 5'b00000);
                set_row(1, {PORT_E, IDLE, IDLE, IDLE, IDLE}, 5'b00000,
                        {IDLE, IDLE, IDLE, PORT_N, IDLE}, 5'b01000);
                set_row(2, {IDLE, IDLE, IDLE, IDLE, PORT_W}, 5'b00000,
                        {IDLE, IDLE, PORT_L, IDLE, IDLE}, 5'b00100);
                // every input asks for its own port
                set_row(3, {PORT_N, PORT_S, PORT_W, PORT_E, PORT_L}, 5'b00000,
                        {IDLE, IDLE, IDLE, IDLE, IDLE}, 5'b00000);
                set_row(4, {IDLE, PORT_S, PORT_S, IDLE, IDLE}, 5'b00000,
                        {IDLE, PORT_W, IDLE, IDLE, IDLE}, 5'b00010);
                // local output, full rotation over four strobes
                set_row(5, {PORT_L, PORT_L, PORT_L, PORT_L, IDLE}, 5'b10000,
                        {IDLE, IDLE, IDLE, IDLE, PORT_N}, 5'b10000);
                set_row(6, {PORT_L, PORT_L, PORT_L, PORT_L, IDLE}, 5'b10000,
                        {IDLE, IDLE, IDLE, IDLE, PORT_S}, 5'b10000);
                set_row(7, {PORT_L, PORT_L, PORT_L, PORT_L, IDLE}, 5'b10000,
                        {IDLE, IDLE, IDLE, IDLE, PORT_W}, 5'b10000);
                set_row(8, {PORT_L, PORT_L, PORT_L, PORT_L, IDLE}, 5'b10000,
                        {IDLE, IDLE, IDLE, IDLE, PORT_E}, 5'b10000);
                // strobes on the other outputs leave the local pointer alone
                set_row(9, {PORT_L, PORT_L, PORT_L, PORT_L, IDLE}, 5'b01111,
                        {IDLE, IDLE, IDLE, IDLE, PORT_N}, 5'b10000);
                set_row(10, {PORT_L, PORT_L, PORT_L, PORT_L, IDLE}, 5'b00000,
                        {IDLE, IDLE, IDLE, IDLE, PORT_N}, 5'b10000);
                set_row(11, {IDLE, IDLE, PORT_L, PORT_L, IDLE}, 5'b00000,
                        {IDLE, IDLE, IDLE, IDLE, PORT_W}, 5'b10000);
                // four outputs at once, pointers of north to east on slot 1
                set_row(12, {PORT_S, PORT_N, PORT_E, PORT_W, PORT_N}, 5'b00000,
                        {PORT_L, PORT_N, PORT_E, PORT_W, IDLE}, 5'b01111);
                set_row(13, {IDLE, PORT_N, PORT_N, PORT_N, PORT_N}, 5'b00001,
                        {PORT_W, IDLE, IDLE, IDLE, IDLE}, 5'b00001);
                set_row(14, {IDLE, PORT_N, PORT_N, PORT_N, PORT_N}, 5'b00011,
                        {PORT_E, IDLE, IDLE, IDLE, IDLE}, 5'b00001);
                set_row(15, {IDLE, PORT_N, PORT_N, PORT_N, PORT_N}, 5'b00000,
                        {PORT_L, IDLE, IDLE, IDLE, IDLE}, 5'b00001);
                set_row(16, {IDLE, IDLE, IDLE, IDLE, IDLE}, 5'b00000,
                        {IDLE, IDLE, IDLE, IDLE, IDLE}, 5'b00000);
        endtask

        initial begin
                int pick;
                int win;
                arst_n_i       = 1'b0;
                n_hop_i        = PORT_NONE;
                s_hop_i        = PORT_NONE;
                w_hop_i        = PORT_NONE;
                e_hop_i        = PORT_NONE;
                l_hop_i        = PORT_NONE;
                change_order_i = '0;
                seed           = 32'h3aea885f;
                for (int p = 0; p < NUM_PORTS; p++) begin
                        model_ptr[p] = 0;
                end
                load_table();

                repeat (RST_CYCLES) @(posedge clk);
                arst_n_i <= 1'b1;

                for (int r = 0; r < NUM_ROWS; r++) begin
                        for (int p = 0; p < NUM_PORTS; p++) begin
                                cur_hop[p] = code_at(tbl_hops[r], p);
                                exp_sel[p] = code_at(tbl_sel[r], p);
                        end
                        cur_strobe = tbl_strobe[r];
                        exp_valid  = tbl_valid[r];
                        drive_cycle();
                        check_all();
                        advance_model();
                end

                for (int i = 0; i < RAND_CYCLES; i++) begin
                        for (int p = 0; p < NUM_PORTS; p++) begin
                                pick       = {$random(seed)} % 6;
                                cur_hop[p] = (pick == 5) ? PORT_NONE : port_t'(pick);
                        end
                        cur_strobe = port_vec_t'($random(seed));
                        drive_cycle();
                        for (int p = 0; p < NUM_PORTS; p++) begin
                                win          = model_winner(p);
                                exp_valid[p] = (win != 7);
                                exp_sel[p]   = port_t'(win);
                        end
                        check_all();
                        advance_model();
                end

                $display("ALL CHECKS PASSED");
                $finish;
        end

endmodule

// ==== files.f ====
router_arb_pkg.sv
nexthop_if.sv
rr_request_decoder.sv
rr_order_register.sv
rr_priority_encoder.sv
rr_port_arbiter.sv
router_arbiter_top.sv
tb_router_arbiter.sv
